// File: include/mem_map.svh
// Region is addr[23:21] of the word address and I/O group is addr[13:12]; include only inside bus_pkg
`ifndef MEM_MAP_SVH
`define MEM_MAP_SVH

// Regions 0 to 2 all hold program ROM
localparam logic [2:0] REG_ROM_LAST = 3'd2;

localparam logic [2:0] REG_RAM  = 3'd3;  // 68000 work RAM
localparam logic [2:0] REG_ORAM = 3'd4;  // Object RAM
localparam logic [2:0] REG_VRAM = 3'd5;  // Tile RAM, char RAM when addr[16] is set
localparam logic [2:0] REG_PAL  = 3'd6;  // Palette RAM
localparam logic [2:0] REG_IO   = 3'd7;

// I/O groups within region 7
localparam logic [1:0] IO_VIDEO = 2'd0;  // Flip and video enable
localparam logic [1:0] IO_CAB   = 2'd1;  // Buttons, coins, joysticks
localparam logic [1:0] IO_DIP   = 2'd2;

`endif

// File: hw/bus_pkg.sv
// CPU bus types for a 68000-style bus with word addresses [23:1]; the memory map header is pulled in here
`default_nettype none

package bus_pkg;

    `include "mem_map.svh"

    typedef logic [2:0] region_t;

    // One CPU bus cycle, held stable while as is high
    typedef struct packed {
        logic        as;     // Address strobe, active high here
        logic        rnw;
        logic [23:1] addr;   // Word address, bit numbers follow the byte address
        logic [15:0] wdata;
        logic [1:0]  dsn;    // {UDSn, LDSn}, active low
    } cpu_req_t;

    typedef struct packed {
        logic        ack;    // Single cycle pulse per bus cycle
        logic [15:0] rdata;
    } cpu_rsp_t;

    // At most one flag set at a time
    typedef struct packed {
        logic rom;
        logic ram;
        logic vram;
        logic char_ram;
        logic obj;
        logic pal;
        logic io;
        logic tbank;    // Tile bank latch, a write into ROM space
    } chip_sel_t;

endpackage

`default_nettype wire

// File: hw/cab_pkg.sv
// Cabinet and video control types; only the low I/O byte carries meaning on writes
`default_nettype none

package cab_pkg;

    typedef struct packed {
        logic [1:0] start;
        logic [1:0] coin;
        logic       service;
        logic       test;
        logic [7:0] joy1;
        logic [7:0] joy2;
        logic [7:0] dip_a;
        logic [7:0] dip_b;
    } cab_in_t;

    typedef struct packed {
        logic       flip;
        logic       video_en;
        logic [5:0] tile_bank;
    } video_ctrl_t;

    // Same write word seen by the video latch and by the tile bank latch
    typedef struct packed {
        logic [8:0] rsvd;
        logic       flip;       // Bit 6
        logic       video_en;   // Bit 5
        logic [4:0] pad;
    } vid_word_t;

    typedef struct packed {
        logic [12:0] rsvd;
        logic [2:0]  half;      // One half of the six-bit bank
    } bank_word_t;

    typedef union packed {
        vid_word_t  vid;
        bank_word_t bank;
    } io_wdata_u;

    // Board wiring scrambles the joystick lines
    function automatic logic [7:0] sort_joy(input logic [7:0] joy);
        return {joy[1:0], joy[3:2], joy[7], joy[5:4], joy[6]};
    endfunction

endpackage

`default_nettype wire

// File: hw/main_region_dec.sv
// Request must stay stable while as is high; ROM_AW up to 22 and ROM address taken straight from addr
`timescale 1ns/1ns
`default_nettype none

module main_region_dec #(
    parameter int ROM_AW = 18
) (
    input  logic                clk,
    input  logic                rst,
    input  bus_pkg::cpu_req_t   req,
    output bus_pkg::chip_sel_t  sel,
    output logic [ROM_AW-1:0]   rom_addr
);
    import bus_pkg::*;

    region_t   region;
    logic      strobe;      // Either byte lane active
    logic      rom_space;
    logic      vram_hi;
    chip_sel_t next_sel;

    assign region    = req.addr[23:21];
    assign strobe    = ~&req.dsn;
    assign rom_space = region <= REG_ROM_LAST;
    assign vram_hi   = req.addr[16];

    always_comb begin
        next_sel          = '0;
        next_sel.rom      = rom_space & req.rnw;
        next_sel.tbank    = rom_space & ~req.rnw;   // ROM writes land on the bank latch
        // Shared RAM only sees cycles with a live byte strobe
        next_sel.ram      = (region == REG_RAM) & strobe;
        next_sel.vram     = (region == REG_VRAM) & ~vram_hi & strobe;
        next_sel.char_ram = (region == REG_VRAM) & vram_hi;
        next_sel.obj      = region == REG_ORAM;
        next_sel.pal      = region == REG_PAL;
        next_sel.io       = region == REG_IO;
    end

    // Selects follow the strobe with one cycle of delay
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel <= '0;
        end else if (req.as) begin
            sel <= next_sel;
        end else begin
            sel <= '0;
        end
    end

    assign rom_addr = req.addr[ROM_AW:1];

    // Downstream muxes and the ack logic count on a single target
    sel_onehot: assert property (
        @(posedge clk) disable iff (rst) $onehot0(sel)
    ) else $error("more than one chip select active");

endmodule

`default_nettype wire

// File: hw/main_io_regs.sv
// Only low byte writes reach the video and bank latches; cabinet byte lags the select by one cycle
`timescale 1ns/1ns
`default_nettype none

module main_io_regs (
    input  logic                 clk,
    input  logic                 rst,
    input  bus_pkg::cpu_req_t    req,
    input  bus_pkg::chip_sel_t   sel,
    input  cab_pkg::cab_in_t     cab,
    output cab_pkg::video_ctrl_t vctrl,
    output logic [7:0]           cab_dout
);
    import bus_pkg::*;
    import cab_pkg::*;

    io_wdata_u  wword;
    logic       wr_lo;      // Write cycle with LDSn low
    logic [1:0] io_group;
    logic [7:0] cab_next;

    assign wword    = req.wdata;
    assign wr_lo    = ~req.rnw & ~req.dsn[0];
    assign io_group = req.addr[13:12];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vctrl.flip      <= 1'b0;
            vctrl.video_en  <= 1'b1;    // Screen on out of reset
            vctrl.tile_bank <= '0;
        end else begin
            if (sel.io && io_group == IO_VIDEO && wr_lo) begin
                vctrl.flip     <= wword.vid.flip;
                vctrl.video_en <= wword.vid.video_en;
            end
            // Bank is loaded three bits at a time
            if (sel.tbank && wr_lo) begin
                if (req.addr[1]) begin
                    vctrl.tile_bank[5:3] <= wword.bank.half;
                end else begin
                    vctrl.tile_bank[2:0] <= wword.bank.half;
                end
            end
        end
    end

    always_comb begin
        cab_next = 8'hff;   // Unmapped reads float high
        if (sel.io) begin
            case (io_group)
                IO_CAB: begin
                    case (req.addr[2:1])
                        2'd0: begin
                            cab_next = {2'b11, cab.start, cab.service, cab.test, cab.coin};
                        end
                        2'd1:    cab_next = sort_joy(cab.joy1);
                        2'd3:    cab_next = sort_joy(cab.joy2);
                        default: cab_next = 8'hff;
                    endcase
                end
                IO_DIP:  cab_next = req.addr[1] ? cab.dip_a : cab.dip_b;
                default: cab_next = 8'hff;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        cab_dout <= cab_next;
    end

endmodule

`default_nettype wire

// File: hw/main_bus_return.sv
// ROM and RAM must keep ok high once raised until their select drops; ack is a clocked pulse, no CPU enable
`timescale 1ns/1ns
`default_nettype none

module main_bus_return (
    input  logic               clk,
    input  logic               rst,
    input  bus_pkg::cpu_req_t  req,
    input  bus_pkg::chip_sel_t sel,
    input  logic [7:0]         cab_dout,
    input  logic [15:0]        rom_data,
    input  logic               rom_ok,
    input  logic [15:0]        ram_data,
    input  logic               ram_ok,
    input  logic [15:0]        char_dout,
    input  logic [15:0]        obj_dout,
    input  logic [15:0]        pal_dout,
    output bus_pkg::cpu_rsp_t  rsp
);
    logic        mem_sel;     // External target, waits on ok
    logic        mem_ok;
    logic        local_sel;
    logic        sel_dly;     // Local select seen for a cycle
    logic        ok_dly;
    logic        ready;
    logic        done;        // Cycle answered, waiting for as to fall
    logic        ack_set;
    logic        ack;
    logic [15:0] rdata;

    assign mem_sel   = sel.rom | sel.ram | sel.vram;
    assign mem_ok    = sel.rom ? rom_ok : ram_ok;
    assign local_sel = sel.char_ram | sel.obj | sel.pal | sel.io | sel.tbank;

    // Local RAMs and the cabinet byte need one cycle after the select
    assign ready   = mem_sel ? (ok_dly & mem_ok) : (local_sel & sel_dly);
    assign ack_set = req.as & ready & ~done;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel_dly <= 1'b0;
            ok_dly  <= 1'b0;
            done    <= 1'b0;
            ack     <= 1'b0;
        end else begin
            sel_dly <= local_sel;
            ok_dly  <= mem_sel & mem_ok;
            ack     <= ack_set;
            done    <= req.as & (done | ack_set);
        end
    end

    always_ff @(posedge clk) begin
        if (sel.ram || sel.vram) begin
            rdata <= ram_data;
        end else if (sel.rom) begin
            rdata <= rom_data;
        end else if (sel.char_ram) begin
            rdata <= char_dout;
        end else if (sel.pal) begin
            rdata <= pal_dout;
        end else if (sel.obj) begin
            rdata <= obj_dout;
        end else if (sel.io) begin
            rdata <= {8'hff, cab_dout};   // I/O is byte wide
        end
    end

    assign rsp.ack   = ack;
    assign rsp.rdata = rdata;

    // CPU holds as until it has seen the ack
    ack_in_cycle: assert property (
        @(posedge clk) disable iff (rst) ack |-> req.as
    ) else $error("ack outside a bus cycle");

    ack_pulse: assert property (
        @(posedge clk) disable iff (rst) ack |=> !ack
    ) else $error("ack held for more than one cycle");

endmodule

`default_nettype wire

// File: hw/main_bus_top.sv
// Main CPU bus glue without CPU core, decryption, sound mapper, watchdog or interrupts
`timescale 1ns/1ns
`default_nettype none

module main_bus_top #(
    parameter int ROM_AW = 18
) (
    input  logic                 clk,
    input  logic                 rst,
    input  bus_pkg::cpu_req_t    req,
    input  cab_pkg::cab_in_t     cab,
    input  logic [15:0]          rom_data,
    input  logic                 rom_ok,
    input  logic [15:0]          ram_data,
    input  logic                 ram_ok,
    input  logic [15:0]          char_dout,
    input  logic [15:0]          obj_dout,
    input  logic [15:0]          pal_dout,
    output bus_pkg::cpu_rsp_t    rsp,
    output bus_pkg::chip_sel_t   sel,
    output logic [ROM_AW-1:0]    rom_addr,
    output logic [15:0]          mem_wdata,
    output logic [1:0]           mem_dsn,
    output cab_pkg::video_ctrl_t vctrl
);
    logic [7:0] cab_dout;

    // Write path goes to every memory untouched
    assign mem_wdata = req.wdata;
    assign mem_dsn   = req.dsn;

    main_region_dec #(
        .ROM_AW   (ROM_AW)
    ) u_dec (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .sel      (sel),
        .rom_addr (rom_addr)
    );

    main_io_regs u_io (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .sel      (sel),
        .cab      (cab),
        .vctrl    (vctrl),
        .cab_dout (cab_dout)
    );

    main_bus_return u_ret (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .sel       (sel),
        .cab_dout  (cab_dout),
        .rom_data  (rom_data),
        .rom_ok    (rom_ok),
        .ram_data  (ram_data),
        .ram_ok    (ram_ok),
        .char_dout (char_dout),
        .obj_dout  (obj_dout),
        .pal_dout  (pal_dout),
        .rsp       (rsp)
    );

endmodule

`default_nettype wire

// File: bench/tb_main_bus.sv
// Random bus cycles from seed 39; ROM and RAM models hold ok until the select drops, RAM window is 32 words
`timescale 1ns/1ns
`default_nettype none

module tb_main_bus;
    import bus_pkg::*;
    import cab_pkg::*;

    localparam int ROM_AW = 18;
    localparam int N_REQ  = 400;
    localparam int WORST  = 12;                         // 5 wait cycles, handshake and gap
    localparam int LIMIT  = 2 * N_REQ * WORST + 200;    // A RAM write brings its own read

    logic              clk;
    logic              rst;
    cpu_req_t          req;
    cab_in_t           cab;
    logic [15:0]       rom_data;
    logic              rom_ok;
    logic [15:0]       ram_data;
    logic              ram_ok;
    logic [15:0]       char_dout;
    logic [15:0]       obj_dout;
    logic [15:0]       pal_dout;
    cpu_rsp_t          rsp;
    chip_sel_t         sel;
    logic [ROM_AW-1:0] rom_addr;
    logic [15:0]       mem_wdata;
    logic [1:0]        mem_dsn;
    video_ctrl_t       vctrl;

    integer      seed = 39;
    int          cycles = 0;
    int          errors;
    int          checks;
    int          strobes;
    int          acks;
    int          mem_delay;         // Wait picked for the current cycle
    int          wait_cnt;
    logic        ok_raised;
    logic [15:0] mem_store [int];   // Memory side contents
    logic [15:0] ref_mem [int];     // Expected contents
    video_ctrl_t ref_vctrl;

    main_bus_top #(
        .ROM_AW    (ROM_AW)
    ) u_dut (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .cab       (cab),
        .rom_data  (rom_data),
        .rom_ok    (rom_ok),
        .ram_data  (ram_data),
        .ram_ok    (ram_ok),
        .char_dout (char_dout),
        .obj_dout  (obj_dout),
        .pal_dout  (pal_dout),
        .rsp       (rsp),
        .sel       (sel),
        .rom_addr  (rom_addr),
        .mem_wdata (mem_wdata),
        .mem_dsn   (mem_dsn),
        .vctrl     (vctrl)
    );

    function automatic logic [15:0] local_word(input logic [3:0] tag, input logic [23:1] a);
        return {tag, a[12:1]};
    endfunction

    function automatic logic [15:0] rom_word(input logic [23:1] a);
        return a[16:1] ^ 16'h5a3c;
    endfunction

    function automatic logic [15:0] merge_bytes(input logic [15:0] old_w,
                                                input logic [15:0] new_w,
                                                input logic [1:0]  dsn);
        return {dsn[1] ? old_w[15:8] : new_w[15:8], dsn[0] ? old_w[7:0] : new_w[7:0]};
    endfunction

    function automatic logic [15:0] stored_word(input logic [23:1] a);
        return mem_store.exists(int'(a)) ? mem_store[int'(a)] : a[16:1];
    endfunction

    function automatic logic [15:0] ref_word(input logic [23:1] a);
        return ref_mem.exists(int'(a)) ? ref_mem[int'(a)] : a[16:1];
    endfunction

    // Board order, high to low: 1 0 3 2 7 5 4 6
    function automatic logic [7:0] reorder_stick(input logic [7:0] j);
        logic [7:0] s;
        s[7] = j[1];
        s[6] = j[0];
        s[5] = j[3];
        s[4] = j[2];
        s[3] = j[7];
        s[2] = j[5];
        s[1] = j[4];
        s[0] = j[6];
        return s;
    endfunction

    function automatic logic [7:0] cab_byte(input logic [23:1] a);
        logic [7:0] b;
        b = 8'hff;
        if (a[13:12] == IO_CAB) begin
            case (a[2:1])
                2'd0:    b = {2'b11, cab.start, cab.service, cab.test, cab.coin};
                2'd1:    b = reorder_stick(cab.joy1);
                2'd3:    b = reorder_stick(cab.joy2);
                default: b = 8'hff;
            endcase
        end else if (a[13:12] == IO_DIP) begin
            b = a[1] ? cab.dip_a : cab.dip_b;
        end
        return b;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("FAILED %0t %s got %h expected %h", $time, name, got, want);
        end
    endtask

    // Local RAMs answer straight from the address
    assign char_dout = local_word(4'h1, req.addr);
    assign obj_dout  = local_word(4'h2, req.addr);
    assign pal_dout  = local_word(4'h3, req.addr);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Timeout: run went past %0d cycles without finishing", LIMIT);
            $display("test failed");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (rsp.ack) begin
            acks++;
        end
    end

    // ROM and shared RAM hold ok until the select drops
    always @(negedge clk) begin
        if (sel.rom || sel.ram || sel.vram) begin
            if (!rom_ok && !ram_ok && wait_cnt >= mem_delay) begin
                ok_raised = 1'b1;
                if (sel.rom) begin
                    rom_ok   = 1'b1;
                    rom_data = rom_word(req.addr);
                end else begin
                    ram_ok = 1'b1;
                    if (req.rnw) begin
                        ram_data = stored_word(req.addr);
                    end else begin
                        check_value("mem_wdata", 32'(mem_wdata), 32'(req.wdata));
                        check_value("mem_dsn", 32'(mem_dsn), 32'(req.dsn));
                        mem_store[int'(req.addr)] = merge_bytes(stored_word(req.addr),
                                                                mem_wdata, mem_dsn);
                    end
                end
            end
            wait_cnt++;
        end else begin
            wait_cnt = 0;
            rom_ok   = 1'b0;
            ram_ok   = 1'b0;
            rom_data = 16'hdead;
            ram_data = 16'hbeef;
        end
    end

    // Starts and ends on a falling edge with as held through the ack cycle
    task automatic bus_cycle(input logic rnw, input logic [23:1] a, input logic [15:0] wd,
                             input logic [1:0] dsn, output logic [15:0] rd);
        logic [31:0] rnd;
        logic        ext;
        rnd       = $random(seed);
        mem_delay = int'(rnd[7:0] % 8'd6);
        ok_raised = 1'b0;
        ext       = (a[23:21] < REG_RAM && rnw) || a[23:21] == REG_RAM
                    || (a[23:21] == REG_VRAM && !a[16]);
        req.as    = 1'b1;
        req.rnw   = rnw;
        req.addr  = a;
        req.wdata = wd;
        req.dsn   = dsn;
        strobes++;
        @(negedge clk);
        while (!rsp.ack) begin
            @(negedge clk);
        end
        rd = rsp.rdata;
        if (ext && !ok_raised) begin
            errors++;
            $display("Ack at %0t came before the memory raised ok", $time);
        end
        if (a[23:21] < REG_RAM && rnw) begin
            check_value("rom_addr", 32'(rom_addr), 32'(a[ROM_AW:1]));
        end
        @(negedge clk);     // CPU samples ack at the rising edge in between
        req.as = 1'b0;
        @(negedge clk);
        check_value("rsp.ack", 32'(rsp.ack), 32'd0);   // Single pulse and none with as low
    endtask

    task automatic random_request();
        logic [31:0] rnd;
        logic [31:0] r2;
        logic [31:0] r3;
        logic [23:1] a;
        logic [15:0] wd;
        logic [1:0]  dsn;
        logic [15:0] rd;
        logic [15:0] want;
        rnd  = $random(seed);
        r2   = $random(seed);
        r3   = $random(seed);
        a    = {3'd0, r2[19:0]};
        wd   = r2[31:16];
        dsn  = rnd[6:5];
        want = 16'h0000;
        case (rnd[2:0])
            3'd0: begin
                a[23:21] = rnd[4:3] == 2'd3 ? 3'd0 : {1'b0, rnd[4:3]};
                bus_cycle(1'b1, a, wd, dsn, rd);
                check_value("rsp.rdata", 32'(rd), 32'(rom_word(a)));
            end
            3'd1: begin
                a[23:21] = rnd[4:3] == 2'd3 ? 3'd1 : {1'b0, rnd[4:3]};
                bus_cycle(1'b0, a, wd, dsn, rd);
                if (!dsn[0]) begin
                    if (a[1]) begin
                        ref_vctrl.tile_bank[5:3] = wd[2:0];
                    end else begin
                        ref_vctrl.tile_bank[2:0] = wd[2:0];
                    end
                end
                check_value("vctrl", 32'(vctrl), 32'(ref_vctrl));
            end
            3'd2, 3'd3: begin
                a = {rnd[0] ? REG_VRAM : REG_RAM, 15'd0, rnd[12:8]};
                if (dsn == 2'b11) begin
                    dsn = 2'b00;    // Shared RAM needs a byte strobe
                end
                if (rnd[7]) begin
                    bus_cycle(1'b0, a, wd, dsn, rd);
                    ref_mem[int'(a)] = merge_bytes(ref_word(a), wd, dsn);
                    dsn = 2'b00;
                end
                want = ref_word(a);
                bus_cycle(1'b1, a, wd, dsn, rd);
                check_value("rsp.rdata", 32'(rd), 32'(want));
            end
            3'd4: begin
                case (rnd[4:3])
                    2'd0: begin
                        a[23:21] = REG_VRAM;
                        a[16]    = 1'b1;
                        want     = local_word(4'h1, a);
                    end
                    2'd1: begin
                        a[23:21] = REG_ORAM;
                        want     = local_word(4'h2, a);
                    end
                    default: begin
                        a[23:21] = REG_PAL;
                        want     = local_word(4'h3, a);
                    end
                endcase
                bus_cycle(1'b1, a, wd, dsn, rd);
                check_value("rsp.rdata", 32'(rd), 32'(want));
            end
            3'd5, 3'd6: begin
                cab      = {r3[5:0], rnd[31:0]};
                cab.joy2 = r3[15:8];
                a[23:21] = REG_IO;
                want     = {8'hff, cab_byte(a)};
                bus_cycle(1'b1, a, wd, dsn, rd);
                check_value("rsp.rdata", 32'(rd), 32'(want));
            end
            default: begin
                a[23:21] = REG_IO;
                a[13:12] = IO_VIDEO;
                bus_cycle(1'b0, a, wd, dsn, rd);
                if (!dsn[0]) begin
                    ref_vctrl.flip     = wd[6];
                    ref_vctrl.video_en = wd[5];
                end
                check_value("vctrl", 32'(vctrl), 32'(ref_vctrl));
            end
        endcase
    endtask

    initial begin
        errors    = 0;
        checks    = 0;
        strobes   = 0;
        acks      = 0;
        wait_cnt  = 0;
        mem_delay = 0;
        ok_raised = 1'b0;
        rst       = 1'b1;
        req       = '0;
        req.rnw   = 1'b1;
        req.dsn   = 2'b11;
        cab       = '0;
        rom_data  = '0;
        rom_ok    = 1'b0;
        ram_data  = '0;
        ram_ok    = 1'b0;
        ref_vctrl.flip      = 1'b0;
        ref_vctrl.video_en  = 1'b1;
        ref_vctrl.tile_bank = 6'd0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_value("vctrl", 32'(vctrl), 32'(ref_vctrl));
            check_value("sel", 32'(sel), 32'd0);
            check_value("rsp.ack", 32'(rsp.ack), 32'd0);
        end
        for (int i = 0; i < N_REQ; i++) begin
            random_request();
        end
        repeat (4) @(negedge clk);
        if (acks != strobes) begin
            errors++;
            $display("Ack count is off, %0d strobes drew %0d acks", strobes, acks);
        end
        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+include
hw/bus_pkg.sv
hw/cab_pkg.sv
hw/main_region_dec.sv
hw/main_io_regs.sv
hw/main_bus_return.sv
hw/main_bus_top.sv
bench/tb_main_bus.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_main_bus
RTL_TOP   ?= main_bus_top
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SOURCES   := $(wildcard hw/*.sv bench/*.sv include/*.svh)

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "test passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
